// ==== bench/predictor_model.svh ====
// Reference model of the BTB, counter table and history, with opcode decode and xorshift

`ifndef PREDICTOR_MODEL_SVH
`define PREDICTOR_MODEL_SVH

// RV32 major opcodes that the predictor tells apart
localparam logic [6:0] JAL_OPCODE    = 7'b1101111;
localparam logic [6:0] JALR_OPCODE   = 7'b1100111;
localparam logic [6:0] BRANCH_OPCODE = 7'b1100011;

// Entry kinds as the model stores them
localparam int NONE_KIND   = 0;
localparam int JUMP_KIND   = 1;
localparam int BRANCH_KIND = 2;

// Mirror of the BTB, indexed by pc[6:2], with the full PC as tag
logic        m_valid  [`BP_BTB_ENTRIES];
logic [31:0] m_tag    [`BP_BTB_ENTRIES];
logic [31:0] m_target [`BP_BTB_ENTRIES];
int          m_kind   [`BP_BTB_ENTRIES];
// Counters run from 0 to 3 and the MSB is the taken guess
logic [1:0]  m_ctr    [1 << `BP_GHR_BITS];
logic [4:0]  m_ghr;

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Jumps of both flavours are unconditional, only conditional branches consult a counter
function automatic int decode_kind(input logic [6:0] op);
    if (op == JAL_OPCODE || op == JALR_OPCODE) begin
        return JUMP_KIND;
    end
    if (op == BRANCH_OPCODE) begin
        return BRANCH_KIND;
    end
    return NONE_KIND;
endfunction

// Puts the model into the state after reset with an empty BTB, zero history
// and every counter weakly taken
task automatic reset_model();
    for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
        m_valid[i]  = 1'b0;
        m_tag[i]    = '0;
        m_target[i] = '0;
        m_kind[i]   = NONE_KIND;
    end
    for (int i = 0; i < (1 << `BP_GHR_BITS); i++) begin
        m_ctr[i] = 2'b10;
    end
    m_ghr = '0;
endtask

// Expected outputs for a fetch PC in the current state
task automatic predict_next(input logic [31:0] pc, output logic taken,
                            output logic [31:0] target, output logic [4:0] index);
    logic [4:0] slot;
    logic       hit;
    slot   = pc[6:2];
    index  = pc[6:2] ^ m_ghr;
    hit    = m_valid[slot] && (m_tag[slot] == pc);
    taken  = hit && (m_kind[slot] == JUMP_KIND ||
                     (m_kind[slot] == BRANCH_KIND && m_ctr[index][1]));
    target = taken ? m_target[slot] : pc + 32'd4;
endtask

// What one clock edge does with the strobes that were applied before it
task automatic apply_update(input logic inst, input logic [31:0] inst_pc,
                            input logic [31:0] inst_target, input logic [6:0] inst_op,
                            input logic res, input logic res_taken,
                            input logic [4:0] res_index, input logic clr);
    if (inst) begin
        m_valid[inst_pc[6:2]]  = 1'b1;
        m_tag[inst_pc[6:2]]    = inst_pc;
        m_target[inst_pc[6:2]] = inst_target;
        m_kind[inst_pc[6:2]]   = decode_kind(inst_op);
    end
    if (res) begin
        if (res_taken && m_ctr[res_index] != 2'b11) begin
            m_ctr[res_index] = m_ctr[res_index] + 2'd1;
        end else if (!res_taken && m_ctr[res_index] != 2'b00) begin
            m_ctr[res_index] = m_ctr[res_index] - 2'd1;
        end
    end
    // Clear wins over the shift of a train in the same cycle
    if (clr) begin
        m_ghr = '0;
    end else if (res) begin
        m_ghr = {res_taken, m_ghr[4:1]};
    end
endtask

`endif

// ==== bench/branch_predictor_tb.sv ====
// Testbench for the branch predictor with directed tests, random traffic and a reference model
`timescale 1ns/1ps

`include "bp_defs.svh"

module branch_predictor_tb;

    // Covers reset, about 60 directed cycles and the random run with some margin
    localparam int CYCLE_LIMIT   = 2300;
    localparam int RANDOM_CYCLES = 2000;

    logic        clk;
    logic        reset_i;
    logic [31:0] pc_i;
    logic [31:0] target_o;
    logic        taken_o;
    logic [4:0]  pht_index_o;
    logic        install_i;
    logic [31:0] install_pc_i;
    logic [31:0] install_target_i;
    logic [6:0]  install_op_i;
    logic        resolve_i;
    logic        resolve_taken_i;
    logic [4:0]  resolve_index_i;
    logic        ghr_clear_i;

    int          cycle_count;
    int          check_count;
    int          error_count;
    int          errors_before;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] rng_state;

    `include "predictor_model.svh"

    branch_predictor i_branch_predictor (
        .clk              (clk),
        .reset_i          (reset_i),
        .pc_i             (pc_i),
        .target_o         (target_o),
        .taken_o          (taken_o),
        .pht_index_o      (pht_index_o),
        .install_i        (install_i),
        .install_pc_i     (install_pc_i),
        .install_target_i (install_target_i),
        .install_op_i     (install_op_i),
        .resolve_i        (resolve_i),
        .resolve_taken_i  (resolve_taken_i),
        .resolve_index_i  (resolve_index_i),
        .ghr_clear_i      (ghr_clear_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Ends a run that stops making progress
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] draw_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // 256 word PCs over 32 slots, so hits and tag aliasing both happen often
    function automatic logic [31:0] random_pc();
        logic [31:0] r;
        r = draw_random();
        return {22'h0, r[9:2], 2'b00};
    endfunction

    task automatic compare_value(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("** Error: %s = %h, expected %h at %0t", sig, got, exp, $time);
            error_count++;
        end
    endtask

    task automatic check_outputs(input logic [31:0] pc);
        logic        exp_taken;
        logic [31:0] exp_target;
        logic [4:0]  exp_index;
        predict_next(pc, exp_taken, exp_target, exp_index);
        compare_value("taken_o", 32'(taken_o), 32'(exp_taken));
        compare_value("target_o", target_o, exp_target);
        compare_value("pht_index_o", 32'(pht_index_o), 32'(exp_index));
    endtask

    // Drives one cycle on the rising edge, compares at the falling edge
    // and then advances the model
    task automatic drive_cycle(input logic [31:0] pc, input logic inst,
                               input logic [31:0] inst_pc, input logic [31:0] inst_target,
                               input logic [6:0] inst_op, input logic res,
                               input logic res_taken, input logic [4:0] res_index,
                               input logic clr);
        @(posedge clk);
        pc_i             <= pc;
        install_i        <= inst;
        install_pc_i     <= inst_pc;
        install_target_i <= inst_target;
        install_op_i     <= inst_op;
        resolve_i        <= res;
        resolve_taken_i  <= res_taken;
        resolve_index_i  <= res_index;
        ghr_clear_i      <= clr;
        @(negedge clk);
        check_outputs(pc);
        apply_update(inst, inst_pc, inst_target, inst_op, res, res_taken, res_index, clr);
    endtask

    task automatic fetch_only(input logic [31:0] pc);
        drive_cycle(pc, 1'b0, '0, '0, '0, 1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic install_entry(input logic [31:0] pc, input logic [31:0] target,
                                 input logic [6:0] op);
        drive_cycle(pc, 1'b1, pc, target, op, 1'b0, 1'b0, '0, 1'b0);
    endtask

    // Resolves the branch at pc with the index it gets this cycle
    task automatic train_branch(input logic [31:0] pc, input logic taken, input logic clr);
        logic        t;
        logic [31:0] tg;
        logic [4:0]  idx;
        predict_next(pc, t, tg, idx);
        drive_cycle(pc, 1'b0, '0, '0, '0, 1'b1, taken, idx, clr);
    endtask

    task automatic finish_test(input string name);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    task automatic jump_test();
        // Lookup in the install cycle still sees the old, empty slot
        install_entry(32'h0000_2044, 32'h0000_8000, JAL_OPCODE);
        fetch_only(32'h0000_2044);
        compare_value("taken_o", 32'(taken_o), 32'd1);
        // Same slot, different tag
        fetch_only(32'h0000_3044);
        compare_value("taken_o", 32'(taken_o), 32'd0);
        install_entry(32'h0000_2044, 32'h0000_9abc, JALR_OPCODE);
        fetch_only(32'h0000_2044);
        compare_value("target_o", target_o, 32'h0000_9abc);
    endtask

    task automatic counter_test();
        install_entry(32'h0000_1108, 32'h0000_0f00, BRANCH_OPCODE);
        fetch_only(32'h0000_1108);
        compare_value("taken_o", 32'(taken_o), 32'd1);
        // Clearing with every train keeps the index on the same counter
        for (int n = 0; n < 4; n++) begin
            train_branch(32'h0000_1108, 1'b0, 1'b1);
        end
        train_branch(32'h0000_1108, 1'b1, 1'b1);
        fetch_only(32'h0000_1108);
        compare_value("taken_o", 32'(taken_o), 32'd0);
        for (int n = 0; n < 4; n++) begin
            train_branch(32'h0000_1108, 1'b1, 1'b1);
        end
        train_branch(32'h0000_1108, 1'b0, 1'b1);
        fetch_only(32'h0000_1108);
        compare_value("taken_o", 32'(taken_o), 32'd1);
        // An ALU opcode allocates a slot that never redirects
        install_entry(32'h0000_1210, 32'h0000_5554, 7'b0110011);
        fetch_only(32'h0000_1210);
        compare_value("target_o", target_o, 32'h0000_1214);
    endtask

    task automatic history_test();
        logic [31:0] r;
        train_branch(32'h0000_0364, 1'b1, 1'b0);
        for (int n = 0; n < 12; n++) begin
            r = draw_random();
            train_branch(random_pc(), r[0], 1'b0);
        end
        train_branch(32'h0000_0364, 1'b1, 1'b1);
        fetch_only(32'h0000_0364);
        compare_value("pht_index_o", 32'(pht_index_o), 32'h19);
        train_branch(32'h0000_0364, 1'b1, 1'b0);
        drive_cycle(32'h0000_0364, 1'b0, '0, '0, '0, 1'b0, 1'b0, '0, 1'b1);
        fetch_only(32'h0000_0364);
        compare_value("pht_index_o", 32'(pht_index_o), 32'h19);
    endtask

    task automatic random_test();
        logic [31:0] pc;
        logic [31:0] r;
        logic [31:0] tgt;
        logic [6:0]  op;
        logic        t;
        logic [31:0] tg;
        logic [4:0]  idx;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            pc  = random_pc();
            r   = draw_random();
            tgt = {draw_random()};
            case (r[5:4])
                2'd0: op = JAL_OPCODE;
                2'd1: op = JALR_OPCODE;
                2'd2: op = BRANCH_OPCODE;
                default: op = 7'b0010011;
            endcase
            // Half the trains use the index of this fetch, the rest a random one
            predict_next(pc, t, tg, idx);
            if (!r[10]) begin
                idx = r[15:11];
            end
            drive_cycle(pc, r[1:0] == 2'b00, random_pc(), {tgt[31:2], 2'b00}, op,
                        r[2], r[3], idx, r[9:6] == 4'd0);
        end
    endtask

    initial begin
        reset_i          <= 1'b1;
        pc_i             <= '0;
        install_i        <= 1'b0;
        install_pc_i     <= '0;
        install_target_i <= '0;
        install_op_i     <= '0;
        resolve_i        <= 1'b0;
        resolve_taken_i  <= 1'b0;
        resolve_index_i  <= '0;
        ghr_clear_i      <= 1'b0;
        check_count   = 0;
        error_count   = 0;
        errors_before = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        rng_state     = 32'd88;
        reset_model();
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        for (int n = 0; n < 20; n++) begin
            fetch_only(draw_random());
        end
        finish_test("after reset");
        jump_test();
        finish_test("jump install");
        counter_test();
        finish_test("branch counters");
        history_test();
        finish_test("history");
        random_test();
        finish_test("random traffic");
        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
+incdir+bench
verilog/bp_pkg.sv
verilog/bp_update_if.sv
verilog/branch_target_buffer.sv
verilog/gshare_pht.sv
verilog/branch_predictor.sv
bench/branch_predictor_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module branch_predictor_tb \
    -f list.f -o branch_predictor_sim > build.log 2>&1 &&
    ./obj_dir/branch_predictor_sim > sim.log 2>&1 ||
    { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "^TESTBENCH PASSED$" sim.log && echo "Simulation passed" && exit 0 ||
    { echo "Simulation failed, see sim.log"; exit 1; }

// ==== verilog/bp_defs.svh ====
// Width and size macros shared by the branch predictor RTL and its testbench

`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// Address width of the fetch and execute PCs
`define BP_XLEN 32

// Number of direct-mapped BTB entries
// The index is taken from the PC word bits, so this should stay a power of two
`define BP_BTB_ENTRIES 32

// Width of the global history register
// The pattern table holds 2**BP_GHR_BITS counters, so this is also its index width
`define BP_GHR_BITS 5

`endif

// ==== verilog/bp_pkg.sv ====
// Branch predictor package with the kind enum, BTB entry, counter type and opcode decode

`include "bp_defs.svh"

package bp_pkg;

    // What the BTB remembers about the instruction at a tagged PC
    // NONE still allocates an entry but never redirects fetch
    typedef enum logic [1:0] {
        KIND_NONE   = 2'b00,
        KIND_JUMP   = 2'b01,
        KIND_BRANCH = 2'b10
    } branch_kind_e;

    // One BTB entry
    // The tag is the full PC, so aliasing between PCs that share an index never hits
    typedef struct packed {
        logic                valid;
        logic [`BP_XLEN-1:0] tag;
        logic [`BP_XLEN-1:0] target;
        branch_kind_e        kind;
    } btb_entry_t;

    // Two-bit saturating counter where the MSB is the taken prediction
    typedef logic [1:0] counter_t;

    // Weakly taken is the state every counter wakes up in
    localparam counter_t CTR_WEAK_TAKEN = 2'b10;

    // RV32 major opcodes that the predictor cares about
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // Both jump flavours are unconditional, conditional branches go to the PHT
    function automatic branch_kind_e opcode_to_kind(input logic [6:0] op);
        if (op == OP_JAL || op == OP_JALR) begin
            return KIND_JUMP;
        end else if (op == OP_BRANCH) begin
            return KIND_BRANCH;
        end
        return KIND_NONE;
    endfunction

endpackage

// ==== verilog/bp_update_if.sv ====
// BTB install and PHT training interfaces between the predictor top and its tables
`timescale 1ns/1ps

`include "bp_defs.svh"

interface btb_update_if;
    import bp_pkg::*;

    // One-cycle install strobe with the resolved PC, its target and its kind
    logic                we;
    logic [`BP_XLEN-1:0] pc;
    logic [`BP_XLEN-1:0] target;
    branch_kind_e        kind;

    modport source (output we, pc, target, kind);
    modport sink   (input  we, pc, target, kind);
endinterface

interface pht_train_if #(
    parameter int IDX_BITS = `BP_GHR_BITS
);
    // Train strobe carries the counter index captured at fetch and the real outcome
    logic                train;
    logic [IDX_BITS-1:0] index;
    logic                taken;
    // History clear pulse, which wins over a shift in the same cycle
    logic                ghr_clear;

    modport source (output train, index, taken, ghr_clear);
    modport sink   (input  train, index, taken, ghr_clear);
endinterface

// ==== verilog/branch_predictor.sv ====
// Fetch-stage branch predictor top combining the BTB and the gshare PHT
`timescale 1ns/1ps

`include "bp_defs.svh"

module branch_predictor (
    input  logic                   clk,
    input  logic                   reset_i,
    // Fetch side
    input  logic [`BP_XLEN-1:0]    pc_i,
    output logic [`BP_XLEN-1:0]    target_o,
    output logic                   taken_o,
    // Counter index the fetch stage should carry down to execute
    output logic [`BP_GHR_BITS-1:0] pht_index_o,
    // BTB install from execute
    input  logic                   install_i,
    input  logic [`BP_XLEN-1:0]    install_pc_i,
    input  logic [`BP_XLEN-1:0]    install_target_i,
    input  logic [6:0]             install_op_i,
    // Branch resolution from execute
    input  logic                   resolve_i,
    input  logic                   resolve_taken_i,
    input  logic [`BP_GHR_BITS-1:0] resolve_index_i,
    input  logic                   ghr_clear_i
);
    import bp_pkg::*;

    btb_update_if btb_upd ();
    pht_train_if  pht_trn ();

    logic                btb_hit;
    branch_kind_e        btb_kind;
    logic [`BP_XLEN-1:0] btb_target;
    logic                pht_taken;

    // Install side
    // The opcode is decoded here so the BTB only ever stores a kind
    assign btb_upd.we     = install_i;
    assign btb_upd.pc     = install_pc_i;
    assign btb_upd.target = install_target_i;
    assign btb_upd.kind   = opcode_to_kind(install_op_i);

    // Training side goes straight through to the PHT
    assign pht_trn.train     = resolve_i;
    assign pht_trn.index     = resolve_index_i;
    assign pht_trn.taken     = resolve_taken_i;
    assign pht_trn.ghr_clear = ghr_clear_i;

    branch_target_buffer i_btb (
        .clk      (clk),
        .reset_i  (reset_i),
        .pc_i     (pc_i),
        .upd      (btb_upd),
        .hit_o    (btb_hit),
        .kind_o   (btb_kind),
        .target_o (btb_target)
    );

    gshare_pht i_pht (
        .clk             (clk),
        .reset_i         (reset_i),
        .pc_i            (pc_i),
        .train           (pht_trn),
        .predict_taken_o (pht_taken),
        .index_o         (pht_index_o)
    );

    // Jumps always redirect on a hit
    // Conditional branches redirect only when their counter leans taken
    // A hit on a NONE entry falls through to the sequential PC
    always_comb begin
        taken_o = 1'b0;
        if (btb_hit) begin
            if (btb_kind == KIND_JUMP) begin
                taken_o = 1'b1;
            end else if (btb_kind == KIND_BRANCH) begin
                taken_o = pht_taken;
            end
        end
    end

    // Next fetch address
    assign target_o = taken_o ? btb_target : pc_i + `BP_XLEN'd4;

endmodule

// ==== verilog/branch_target_buffer.sv ====
// Direct-mapped branch target buffer with combinational lookup and clocked install
`timescale 1ns/1ps

`include "bp_defs.svh"

module branch_target_buffer #(
    parameter int ENTRIES = `BP_BTB_ENTRIES
) (
    input  logic                 clk,
    input  logic                 reset_i,
    // Fetch PC to look up in this cycle
    input  logic [`BP_XLEN-1:0]  pc_i,
    // Install port from the execute stage
    btb_update_if.sink           upd,
    output logic                 hit_o,
    output bp_pkg::branch_kind_e kind_o,
    output logic [`BP_XLEN-1:0]  target_o
);
    import bp_pkg::*;

    // Index bits come from the PC just above the two byte-offset bits
    localparam int IDX_BITS = $clog2(ENTRIES);

    // The table of entries
    // An entry takes part in a lookup only while its valid bit is set
    btb_entry_t entries [ENTRIES];

    logic [IDX_BITS-1:0] rd_idx;
    logic [IDX_BITS-1:0] wr_idx;
    btb_entry_t          rd_entry;
    btb_entry_t          wr_entry;

    // Read side index for the current fetch PC
    assign rd_idx = pc_i[IDX_BITS+1:2];

    // Write side index for the PC being installed
    // This is independent of the fetch PC, so fetch and install never collide
    // on a port even when they land in the same entry
    assign wr_idx = upd.pc[IDX_BITS+1:2];

    // Assemble the new entry
    // The tag is the whole install PC, matching what the lookup compares against
    always_comb begin
        wr_entry.valid  = 1'b1;
        wr_entry.tag    = upd.pc;
        wr_entry.target = upd.target;
        wr_entry.kind   = upd.kind;
    end

    // Install path
    // An install simply replaces whatever sits at the index
    // If the same PC is already there this rewrites it with identical tag,
    // and a fresh target takes effect from the next cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            // Every slot starts empty so nothing can hit right after reset
            for (int i = 0; i < ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (upd.we) begin
            entries[wr_idx] <= wr_entry;
        end
    end

    // Lookup path
    // Purely combinational from pc_i
    // A write in the same cycle is not forwarded, so the old contents are seen
    assign rd_entry = entries[rd_idx];

    // A hit needs a valid slot whose stored PC is exactly the fetch PC
    assign hit_o = rd_entry.valid && (rd_entry.tag == pc_i);

    // Kind and target are passed through raw
    // The top level qualifies them with hit_o before using them
    assign kind_o   = rd_entry.kind;
    assign target_o = rd_entry.target;

endmodule

// ==== verilog/gshare_pht.sv ====
// Gshare pattern history table with global history register and saturating counters
`timescale 1ns/1ps

`include "bp_defs.svh"

module gshare_pht #(
    parameter int GHR_BITS = `BP_GHR_BITS
) (
    input  logic                clk,
    input  logic                reset_i,
    // Fetch PC used to form the read index
    input  logic [`BP_XLEN-1:0] pc_i,
    // Training and history clear from the execute stage
    pht_train_if.sink           train,
    output logic                predict_taken_o,
    output logic [GHR_BITS-1:0] index_o
);
    import bp_pkg::*;

    localparam int PHT_ENTRIES = 1 << GHR_BITS;

    // Global history
    // The newest resolved outcome sits in the MSB and older ones move toward bit 0
    logic [GHR_BITS-1:0] ghr;

    // Counter table, one 2-bit saturating counter per index
    counter_t counters [PHT_ENTRIES];

    logic [GHR_BITS-1:0] rd_idx;

    // Moves a counter one step toward the outcome and holds it at either end
    function automatic counter_t step_counter(input counter_t cur, input logic up);
        counter_t nxt;
        nxt = cur;
        if (up && cur != 2'b11) begin
            nxt = cur + 2'd1;
        end else if (!up && cur != 2'b00) begin
            nxt = cur - 2'd1;
        end
        return nxt;
    endfunction

    // Gshare hashing of the PC word bits with the history
    assign rd_idx  = pc_i[GHR_BITS+1:2] ^ ghr;
    assign index_o = rd_idx;

    // The prediction is just the counter MSB
    // As in the BTB, a train in the same cycle is not forwarded
    assign predict_taken_o = counters[rd_idx][1];

    // Counter training
    // Uses the index that the execute stage carried along, not today's index,
    // because the history has usually moved on since that branch was fetched
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                counters[i] <= CTR_WEAK_TAKEN;
            end
        end else if (train.train) begin
            counters[train.index] <= step_counter(counters[train.index], train.taken);
        end
    end

    // History register
    // A clear pulse beats a shift that arrives on the same edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr <= '0;
        end else if (train.ghr_clear) begin
            ghr <= '0;
        end else if (train.train) begin
            // Resolved outcome enters at the top
            ghr <= {train.taken, ghr[GHR_BITS-1:1]};
        end
    end

endmodule
